// File: src.f
logic/isa_pkg.sv
logic/core_pkg.sv
logic/stage_if.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/memory_unit.sv
logic/proc.sv
test/tb_proc.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_proc with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f src.f --top-module tb_proc -Mdir obj_dir -o tb_proc
	./obj_dir/tb_proc

clean:
	rm -rf obj_dir

// File: test/tb_proc.sv
`timescale 1ns/1ps

module tb_proc
   import isa_pkg::*, core_pkg::*;
();

   localparam int RESET_CYCLES = 5;
   localparam int HALT_TIMEOUT = 400;
   localparam int QUIET_CYCLES = 20;
   localparam int RANDOM_PROGS = 4;
   localparam int RANDOM_LEN   = 40;

   logic              clk;
   logic              rst_n_i;
   logic              imem_we_i;
   logic [ADDR_W-1:0] imem_addr_i;
   logic [WORD_W-1:0] imem_wdata_i;
   logic              wb_valid_o;
   logic [REG_W-1:0]  wb_reg_o;
   logic [WORD_W-1:0] wb_data_o;
   logic              halt_o;
   logic              err_o;

   string             test_name;
   logic [WORD_W-1:0] prog_q [$];
   logic [REG_W-1:0]  exp_reg_q [$];
   logic [WORD_W-1:0] exp_data_q [$];
   logic              exp_halt;
   logic              exp_err;

   proc dut0 (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .imem_we_i    (imem_we_i),
      .imem_addr_i  (imem_addr_i),
      .imem_wdata_i (imem_wdata_i),
      .wb_valid_o   (wb_valid_o),
      .wb_reg_o     (wb_reg_o),
      .wb_data_o    (wb_data_o),
      .halt_o       (halt_o),
      .err_o        (err_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_run(string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic value_error(string what, logic [WORD_W-1:0] expected,
                              logic [WORD_W-1:0] actual);
      stop_run($sformatf("** Error [%s] %s: expected 0x%h, actual 0x%h",
                         test_name, what, expected, actual));
   endtask

   // instruction encoders for the stimulus
   function automatic logic [WORD_W-1:0] r_word(logic [1:0] func, logic [2:0] rs,
                                                logic [2:0] rt, logic [2:0] rd);
      return {OP_ALU_R, rs, rt, rd, func};
   endfunction

   function automatic logic [WORD_W-1:0] i_word(logic [4:0] op, logic [2:0] rs,
                                                logic [2:0] rd, logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [WORD_W-1:0] lbi_word(logic [2:0] rs, logic [7:0] imm);
      return {OP_LBI, rs, imm};
   endfunction

   // ISA model of prog_q that fills the expected writes and end state
   function automatic void model_program();
      logic [WORD_W-1:0] rf [NUM_REGS];
      logic [WORD_W-1:0] dm [DMEM_DEPTH];
      logic [WORD_W-1:0] w;
      logic [WORD_W-1:0] imm5;
      logic [WORD_W-1:0] sum;
      logic [WORD_W-1:0] wr_val;
      logic [REG_W-1:0]  rs;
      logic [REG_W-1:0]  wr_reg;
      logic              wr_en;
      logic              done;
      exp_reg_q.delete();
      exp_data_q.delete();
      exp_halt = 1'b0;
      exp_err  = 1'b0;
      done     = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
         rf[i] = '0;
      end
      for (int pc = 0; pc < prog_q.size() && !done; pc++) begin
         w      = prog_q[pc];
         rs     = w[10:8];
         imm5   = {{(WORD_W-5){w[4]}}, w[4:0]};
         sum    = rf[rs] + imm5;
         wr_en  = 1'b1;
         wr_reg = w[7:5];
         wr_val = '0;
         case (w[15:11])
            OP_HALT: begin
               wr_en    = 1'b0;
               exp_halt = 1'b1;
               done     = 1'b1;
            end
            OP_NOP: wr_en = 1'b0;
            OP_ADDI: wr_val = sum;
            OP_SUBI: wr_val = rf[rs] - imm5;
            OP_ST: begin
               wr_en = 1'b0;
               dm[sum[ADDR_W-1:0]] = rf[w[7:5]];
            end
            OP_LD: wr_val = dm[sum[ADDR_W-1:0]];
            OP_LBI: begin
               wr_reg = rs;
               wr_val = {{8{w[7]}}, w[7:0]};
            end
            OP_ALU_R: begin
               wr_reg = w[4:2];
               case (w[1:0])
                  FN_ADD: wr_val = rf[rs] + rf[w[7:5]];
                  FN_SUB: wr_val = rf[rs] - rf[w[7:5]];
                  FN_AND: wr_val = rf[rs] & rf[w[7:5]];
                  FN_XOR: wr_val = rf[rs] ^ rf[w[7:5]];
               endcase
            end
            default: begin
               wr_en    = 1'b0;
               exp_halt = 1'b1;
               exp_err  = 1'b1;
               done     = 1'b1;
            end
         endcase
         if (wr_en) begin
            rf[wr_reg] = wr_val;
            exp_reg_q.push_back(wr_reg);
            exp_data_q.push_back(wr_val);
         end
      end
   endfunction

   function automatic void build_random();
      int unsigned sel;
      logic [31:0] r;
      prog_q.delete();
      for (int i = 0; i < RANDOM_LEN; i++) begin
         sel = $urandom % 7;
         r   = $urandom;
         case (sel)
            0: prog_q.push_back(lbi_word(r[2:0], r[10:3]));
            1: prog_q.push_back(i_word(OP_ADDI, r[2:0], r[5:3], r[10:6]));
            2: prog_q.push_back(i_word(OP_SUBI, r[2:0], r[5:3], r[10:6]));
            3: prog_q.push_back(r_word(FN_ADD, r[2:0], r[5:3], r[8:6]));
            4: prog_q.push_back(r_word(FN_SUB, r[2:0], r[5:3], r[8:6]));
            5: prog_q.push_back(r_word(FN_AND, r[2:0], r[5:3], r[8:6]));
            default: prog_q.push_back(r_word(FN_XOR, r[2:0], r[5:3], r[8:6]));
         endcase
      end
      prog_q.push_back({OP_HALT, 11'd0});
   endfunction

   task automatic check_idle();
      assert (wb_valid_o === 1'b0 && halt_o === 1'b0 && err_o === 1'b0)
      else value_error("{wb_valid,halt,err} in reset", '0, 16'({wb_valid_o, halt_o, err_o}));
   endtask

   // compare every retired write with the head of the expected list
   always @(negedge clk) begin
      if (rst_n_i && wb_valid_o) begin
         if (exp_reg_q.size() == 0) begin
            stop_run($sformatf("[%s] unexpected write to r%0d beyond the expected writes",
                               test_name, wb_reg_o));
         end else begin
            assert (wb_reg_o == exp_reg_q[0])
            else value_error("write register", 16'(exp_reg_q[0]), 16'(wb_reg_o));
            assert (wb_data_o == exp_data_q[0])
            else value_error($sformatf("r%0d value", exp_reg_q[0]), exp_data_q[0], wb_data_o);
            void'(exp_reg_q.pop_front());
            void'(exp_data_q.pop_front());
         end
      end
   end

   task automatic run_program(string name);
      int cycles;
      test_name = name;
      model_program();
      @(posedge clk);
      rst_n_i <= 1'b0;
      // load while the core sits in reset
      for (int i = 0; i < prog_q.size(); i++) begin
         imem_we_i    <= 1'b1;
         imem_addr_i  <= ADDR_W'(i);
         imem_wdata_i <= prog_q[i];
         @(posedge clk);
      end
      imem_we_i <= 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(negedge clk);
         check_idle();
         @(posedge clk);
      end
      rst_n_i <= 1'b1;
      @(negedge clk);
      check_idle();
      cycles = 0;
      while (halt_o !== 1'b1) begin
         if (cycles >= HALT_TIMEOUT) begin
            stop_run($sformatf("[%s] halt_o did not rise within %0d cycles",
                               test_name, HALT_TIMEOUT));
         end
         cycles++;
         @(negedge clk);
      end
      assert (err_o == exp_err) else value_error("err_o at halt", 16'(exp_err), 16'(err_o));
      // nothing behind the halt may retire
      repeat (QUIET_CYCLES) @(negedge clk);
      assert (halt_o == exp_halt && err_o == exp_err)
      else value_error("{halt,err} after halt", 16'({exp_halt, exp_err}), 16'({halt_o, err_o}));
      assert (exp_reg_q.size() == 0)
      else stop_run($sformatf("[%s] %0d expected writes never appeared",
                              test_name, exp_reg_q.size()));
   endtask

   initial begin
      rst_n_i      <= 1'b0;
      imem_we_i    <= 1'b0;
      imem_addr_i  <= '0;
      imem_wdata_i <= '0;
      void'($urandom(32'hfbd9be8e));
      for (int n = 0; n < RANDOM_PROGS; n++) begin
         build_random();
         run_program($sformatf("random_%0d", n));
      end
      // each step reads the previous destination
      prog_q.delete();
      prog_q.push_back(lbi_word(3'd1, 8'd5));
      prog_q.push_back(i_word(OP_ADDI, 3'd1, 3'd2, 5'd3));
      prog_q.push_back(r_word(FN_SUB, 3'd2, 3'd1, 3'd3));
      prog_q.push_back(r_word(FN_XOR, 3'd3, 3'd2, 3'd4));
      prog_q.push_back(r_word(FN_AND, 3'd4, 3'd3, 3'd5));
      prog_q.push_back(i_word(OP_SUBI, 3'd5, 3'd6, 5'h1e));
      prog_q.push_back(r_word(FN_ADD, 3'd6, 3'd6, 3'd7));
      prog_q.push_back(i_word(OP_ADDI, 3'd7, 3'd7, 5'h11));
      prog_q.push_back({OP_HALT, 11'd0});
      run_program("dep_chain");
      // stores at 40, 45, 36 and a wrapped address 2
      prog_q.delete();
      prog_q.push_back(lbi_word(3'd1, 8'h11));
      prog_q.push_back(lbi_word(3'd2, 8'hfd));
      prog_q.push_back(r_word(FN_ADD, 3'd1, 3'd2, 3'd3));
      prog_q.push_back(lbi_word(3'd4, 8'd40));
      prog_q.push_back(i_word(OP_ST, 3'd4, 3'd1, 5'd0));
      prog_q.push_back(i_word(OP_ST, 3'd4, 3'd2, 5'd5));
      prog_q.push_back(i_word(OP_ST, 3'd4, 3'd3, 5'h1c));
      prog_q.push_back(lbi_word(3'd0, 8'hff));
      prog_q.push_back({OP_NOP, 11'd0});
      prog_q.push_back(i_word(OP_ST, 3'd0, 3'd4, 5'd3));
      prog_q.push_back(i_word(OP_LD, 3'd4, 3'd5, 5'd0));
      prog_q.push_back(i_word(OP_LD, 3'd4, 3'd6, 5'd5));
      prog_q.push_back(i_word(OP_LD, 3'd4, 3'd7, 5'h1c));
      prog_q.push_back(i_word(OP_LD, 3'd0, 3'd1, 5'd3));
      prog_q.push_back({OP_HALT, 11'd0});
      run_program("store_load");
      prog_q.delete();
      prog_q.push_back(lbi_word(3'd1, 8'd9));
      prog_q.push_back(i_word(OP_ADDI, 3'd1, 3'd2, 5'd1));
      prog_q.push_back({OP_HALT, 11'd0});
      prog_q.push_back(i_word(OP_ADDI, 3'd2, 3'd3, 5'd1));
      prog_q.push_back(lbi_word(3'd4, 8'd7));
      prog_q.push_back(r_word(FN_ADD, 3'd1, 3'd2, 3'd5));
      prog_q.push_back({OP_HALT, 11'd0});
      run_program("halt_stop");
      // opcode 00111 is not in the instruction set
      prog_q.delete();
      prog_q.push_back(lbi_word(3'd1, 8'd3));
      prog_q.push_back(i_word(OP_ADDI, 3'd1, 3'd2, 5'd4));
      prog_q.push_back(r_word(FN_XOR, 3'd1, 3'd2, 3'd3));
      prog_q.push_back({5'b00111, 11'h2a5});
      prog_q.push_back(lbi_word(3'd4, 8'd1));
      prog_q.push_back(i_word(OP_ADDI, 3'd4, 3'd5, 5'd1));
      prog_q.push_back({OP_HALT, 11'd0});
      run_program("illegal_op");
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// File: logic/proc.sv
`timescale 1ns/1ps

module proc
   import isa_pkg::*, core_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              imem_we_i,
   input  logic [ADDR_W-1:0] imem_addr_i,
   input  logic [WORD_W-1:0] imem_wdata_i,
   output logic              wb_valid_o,
   output logic [REG_W-1:0]  wb_reg_o,
   output logic [WORD_W-1:0] wb_data_o,
   output logic              halt_o,
   output logic              err_o
);

   logic              fd_valid;
   instr_u            fd_instr;
   logic              stall;
   logic [REG_W-1:0]  rd_addr_a;
   logic [REG_W-1:0]  rd_addr_b;
   logic              src_a_used;
   logic              src_b_used;
   logic [WORD_W-1:0] rd_data_a;
   logic [WORD_W-1:0] rd_data_b;

   // pipeline registers between stages
   stage_if de_bus ();
   stage_if em_bus ();
   stage_if mw_bus ();

   fetch_unit fetch0 (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .imem_we_i    (imem_we_i),
      .imem_addr_i  (imem_addr_i),
      .imem_wdata_i (imem_wdata_i),
      .stall_i      (stall),
      .fd_valid_o   (fd_valid),
      .fd_instr_o   (fd_instr)
   );

   decode_unit decode0 (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .fd_valid_i   (fd_valid),
      .fd_instr_i   (fd_instr),
      .stall_i      (stall),
      .rd_data_a_i  (rd_data_a),
      .rd_data_b_i  (rd_data_b),
      .rd_addr_a_o  (rd_addr_a),
      .rd_addr_b_o  (rd_addr_b),
      .src_a_used_o (src_a_used),
      .src_b_used_o (src_b_used),
      .de           (de_bus.producer)
   );

   hazard_unit hazard0 (
      .rd_addr_a_i  (rd_addr_a),
      .rd_addr_b_i  (rd_addr_b),
      .src_a_used_i (src_a_used),
      .src_b_used_i (src_b_used),
      .ex           (de_bus.monitor),
      .mem          (em_bus.monitor),
      .stall_o      (stall)
   );

   // writeback happens here, straight off mw_bus
   reg_file regs0 (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .rd_addr_a_i (rd_addr_a),
      .rd_addr_b_i (rd_addr_b),
      .wb          (mw_bus.consumer),
      .rd_data_a_o (rd_data_a),
      .rd_data_b_o (rd_data_b)
   );

   execute_unit execute0 (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .de      (de_bus.consumer),
      .em      (em_bus.producer)
   );

   memory_unit memory0 (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .em      (em_bus.consumer),
      .mw      (mw_bus.producer),
      .halt_o  (halt_o),
      .err_o   (err_o)
   );

   // trace of every retired register write
   assign wb_valid_o = mw_bus.valid & mw_bus.reg_wr;
   assign wb_reg_o   = mw_bus.rd;
   assign wb_data_o  = mw_bus.result;

endmodule

// File: logic/memory_unit.sv
`timescale 1ns/1ps

module memory_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   stage_if.consumer em,
   stage_if.producer mw,
   output logic      halt_o,
   output logic      err_o
);

   logic [WORD_W-1:0] dmem [DMEM_DEPTH];
   logic [ADDR_W-1:0] addr;
   logic [WORD_W-1:0] load_word;
   logic              halt_q;
   logic              err_q;

   // effective address is the low bits of rs + imm5
   assign addr      = em.result[ADDR_W-1:0];
   assign load_word = em.mem_rd ? dmem[addr] : '0;

   always_ff @(posedge clk) begin
      if (em.valid && em.mem_wr) begin
         dmem[addr] <= em.store_data;
      end
   end

   // flags rise as the halting instruction lands on mw
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         mw.valid <= 1'b0;
         halt_q   <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         mw.valid <= em.valid;
         if (em.valid && em.halt) begin
            halt_q <= 1'b1;
            err_q  <= err_q | em.err;
         end
      end
   end

   always_ff @(posedge clk) begin
      mw.alu_op     <= em.alu_op;
      mw.wb_src     <= em.wb_src;
      mw.rd         <= em.rd;
      mw.reg_wr     <= em.reg_wr;
      mw.mem_rd     <= em.mem_rd;
      mw.mem_wr     <= em.mem_wr;
      mw.halt       <= em.halt;
      mw.err        <= em.err;
      mw.opa        <= em.opa;
      mw.opb        <= em.opb;
      mw.store_data <= em.store_data;
      mw.result     <= (em.wb_src == WB_MEM) ? load_word : em.result;
   end

   assign halt_o = halt_q;
   assign err_o  = err_q;

endmodule

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   stage_if.consumer de,
   stage_if.producer em
);

   logic [WORD_W-1:0] alu_out;

   // sub is opa minus opb
   always_comb begin
      unique case (de.alu_op)
         ALU_ADD: alu_out = de.opa + de.opb;
         ALU_SUB: alu_out = de.opa - de.opb;
         ALU_AND: alu_out = de.opa & de.opb;
         ALU_XOR: alu_out = de.opa ^ de.opb;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         em.valid <= 1'b0;
      end else begin
         em.valid <= de.valid;
      end
   end

   // payload of the execute/memory register
   always_ff @(posedge clk) begin
      em.alu_op     <= de.alu_op;
      em.wb_src     <= de.wb_src;
      em.rd         <= de.rd;
      em.reg_wr     <= de.reg_wr;
      em.mem_rd     <= de.mem_rd;
      em.mem_wr     <= de.mem_wr;
      em.halt       <= de.halt;
      em.err        <= de.err;
      em.opa        <= de.opa;
      em.opb        <= de.opb;
      em.store_data <= de.store_data;
      em.result     <= alu_out;
   end

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
   import isa_pkg::*;
(
   input  logic             [REG_W-1:0] rd_addr_a_i,
   input  logic             [REG_W-1:0] rd_addr_b_i,
   input  logic             src_a_used_i,
   input  logic             src_b_used_i,
   stage_if.monitor         ex,
   stage_if.monitor         mem,
   output logic             stall_o
);

   logic ex_writes;
   logic mem_writes;
   logic a_hit;
   logic b_hit;

   // writeback is covered by the register file bypass
   assign ex_writes  = ex.valid & ex.reg_wr;
   assign mem_writes = mem.valid & mem.reg_wr;

   assign a_hit = (ex_writes && ex.rd == rd_addr_a_i) || (mem_writes && mem.rd == rd_addr_a_i);
   assign b_hit = (ex_writes && ex.rd == rd_addr_b_i) || (mem_writes && mem.rd == rd_addr_b_i);

   assign stall_o = (src_a_used_i & a_hit) | (src_b_used_i & b_hit);

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file
   import isa_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic [REG_W-1:0]  rd_addr_a_i,
   input  logic [REG_W-1:0]  rd_addr_b_i,
   stage_if.consumer         wb,
   output logic [WORD_W-1:0] rd_data_a_o,
   output logic [WORD_W-1:0] rd_data_b_o
);

   logic [WORD_W-1:0] regs [NUM_REGS];
   logic              wr_en;

   assign wr_en = wb.valid & wb.reg_wr;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.result;
      end
   end

   // same-cycle write is bypassed to the reader
   assign rd_data_a_o = (wr_en && wb.rd == rd_addr_a_i) ? wb.result : regs[rd_addr_a_i];
   assign rd_data_b_o = (wr_en && wb.rd == rd_addr_b_i) ? wb.result : regs[rd_addr_b_i];

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              fd_valid_i,
   input  instr_u            fd_instr_i,
   input  logic              stall_i,
   input  logic [WORD_W-1:0] rd_data_a_i,
   input  logic [WORD_W-1:0] rd_data_b_i,
   output logic [REG_W-1:0]  rd_addr_a_o,
   output logic [REG_W-1:0]  rd_addr_b_o,
   output logic              src_a_used_o,
   output logic              src_b_used_o,
   stage_if.producer         de
);

   logic [OPC_W-1:0]    opcode;
   logic                halted_q;
   logic                live;
   logic [ALU_OP_W-1:0] alu_op;
   logic [WB_SRC_W-1:0] wb_src;
   logic [REG_W-1:0]    dest;
   logic                reg_wr;
   logic                mem_rd;
   logic                mem_wr;
   logic                halt;
   logic                illegal;
   logic                use_a;
   logic                use_b;
   logic [WORD_W-1:0]   imm5_ext;
   logic [WORD_W-1:0]   imm8_ext;
   logic [WORD_W-1:0]   opa;
   logic [WORD_W-1:0]   opb;

   assign opcode   = fd_instr_i.r_fmt.opcode;
   assign imm5_ext = {{(WORD_W-IMM_W){fd_instr_i.i_fmt.imm5[IMM_W-1]}},
                      fd_instr_i.i_fmt.imm5};
   assign imm8_ext = {{(WORD_W-LBI_IMM_W){fd_instr_i[LBI_IMM_W-1]}},
                      fd_instr_i[LBI_IMM_W-1:0]};

   // st keeps its data register in the rt bits
   assign rd_addr_a_o = fd_instr_i.r_fmt.rs;
   assign rd_addr_b_o = fd_instr_i.r_fmt.rt;

   always_comb begin
      alu_op  = ALU_ADD;
      wb_src  = WB_ALU;
      dest    = fd_instr_i.i_fmt.rd;
      reg_wr  = 1'b0;
      mem_rd  = 1'b0;
      mem_wr  = 1'b0;
      halt    = 1'b0;
      illegal = 1'b0;
      use_a   = 1'b0;
      use_b   = 1'b0;
      opa     = rd_data_a_i;
      opb     = imm5_ext;
      case (opcode)
         OP_HALT: halt = 1'b1;
         OP_NOP: begin
         end
         OP_ADDI: begin
            reg_wr = 1'b1;
            use_a  = 1'b1;
         end
         OP_SUBI: begin
            alu_op = ALU_SUB;
            reg_wr = 1'b1;
            use_a  = 1'b1;
         end
         OP_ST: begin
            mem_wr = 1'b1;
            use_a  = 1'b1;
            use_b  = 1'b1;
         end
         OP_LD: begin
            mem_rd = 1'b1;
            wb_src = WB_MEM;
            reg_wr = 1'b1;
            use_a  = 1'b1;
         end
         OP_LBI: begin
            // 0 + immediate into rs
            dest   = fd_instr_i.i_fmt.rs;
            reg_wr = 1'b1;
            opa    = '0;
            opb    = imm8_ext;
         end
         OP_ALU_R: begin
            dest   = fd_instr_i.r_fmt.rd;
            reg_wr = 1'b1;
            use_a  = 1'b1;
            use_b  = 1'b1;
            opb    = rd_data_b_i;
            case (fd_instr_i.r_fmt.func)
               FN_ADD: alu_op = ALU_ADD;
               FN_SUB: alu_op = ALU_SUB;
               FN_AND: alu_op = ALU_AND;
               FN_XOR: alu_op = ALU_XOR;
            endcase
         end
         default: begin
            // unknown opcode stops the core with an error
            illegal = 1'b1;
            halt    = 1'b1;
         end
      endcase
   end

   // nothing after a halt is decoded
   assign live         = fd_valid_i & ~halted_q;
   assign src_a_used_o = live & use_a;
   assign src_b_used_o = live & use_b;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         de.valid <= 1'b0;
         halted_q <= 1'b0;
      end else begin
         // bubble on stall
         de.valid <= live & ~stall_i;
         if (live && !stall_i && halt) begin
            halted_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      de.alu_op     <= alu_op;
      de.wb_src     <= wb_src;
      de.rd         <= dest;
      de.reg_wr     <= reg_wr;
      de.mem_rd     <= mem_rd;
      de.mem_wr     <= mem_wr;
      de.halt       <= halt;
      de.err        <= illegal;
      de.opa        <= opa;
      de.opb        <= opb;
      de.store_data <= rd_data_b_i;
   end

   // result is produced in execute
   assign de.result = '0;

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
   import isa_pkg::*, core_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n_i,
   input  logic              imem_we_i,
   input  logic [ADDR_W-1:0] imem_addr_i,
   input  logic [WORD_W-1:0] imem_wdata_i,
   input  logic              stall_i,
   output logic              fd_valid_o,
   output instr_u            fd_instr_o
);

   logic [WORD_W-1:0] imem [IMEM_DEPTH];
   logic [ADDR_W-1:0] pc_q;

   // program load port, usable at any time
   always_ff @(posedge clk) begin
      if (imem_we_i) begin
         imem[imem_addr_i] <= imem_wdata_i;
      end
   end

   // pc and the valid bit of the fetch/decode register
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pc_q       <= '0;
         fd_valid_o <= 1'b0;
      end else if (!stall_i) begin
         pc_q       <= pc_q + ADDR_W'(1);
         fd_valid_o <= 1'b1;
      end
   end

   // instruction word held while decode stalls
   always_ff @(posedge clk) begin
      if (!stall_i) begin
         fd_instr_o <= imem[pc_q];
      end
   end

endmodule

// File: logic/stage_if.sv
`timescale 1ns/1ps

interface stage_if
   import isa_pkg::*, core_pkg::*;
();

   logic                valid;
   logic [ALU_OP_W-1:0] alu_op;
   logic [WB_SRC_W-1:0] wb_src;
   logic [REG_W-1:0]    rd;
   logic                reg_wr;
   logic                mem_rd;
   logic                mem_wr;
   logic                halt;
   logic                err;
   logic [WORD_W-1:0]   opa;
   logic [WORD_W-1:0]   opb;
   logic [WORD_W-1:0]   store_data;
   logic [WORD_W-1:0]   result;

   modport producer (output valid, alu_op, wb_src, rd, reg_wr, mem_rd, mem_wr,
                     halt, err, opa, opb, store_data, result);

   modport consumer (input valid, alu_op, wb_src, rd, reg_wr, mem_rd, mem_wr,
                     halt, err, opa, opb, store_data, result);

   // only what the hazard check needs
   modport monitor (input valid, rd, reg_wr);

endinterface

// File: logic/core_pkg.sv
package core_pkg;

   // word addressed memories
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam int ADDR_W     = 8;

   // alu operations
   localparam int ALU_OP_W = 2;
   localparam logic [ALU_OP_W-1:0] ALU_ADD = 2'd0;
   localparam logic [ALU_OP_W-1:0] ALU_SUB = 2'd1;
   localparam logic [ALU_OP_W-1:0] ALU_AND = 2'd2;
   localparam logic [ALU_OP_W-1:0] ALU_XOR = 2'd3;

   // where the written-back value comes from
   localparam int WB_SRC_W = 1;
   localparam logic [WB_SRC_W-1:0] WB_ALU = 1'b0;
   localparam logic [WB_SRC_W-1:0] WB_MEM = 1'b1;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

   // data word and instruction share one width
   localparam int WORD_W   = 16;
   localparam int REG_W    = 3;
   localparam int NUM_REGS = 8;

   // instruction field widths
   localparam int OPC_W     = 5;
   localparam int FUNC_W    = 2;
   localparam int IMM_W     = 5;
   localparam int LBI_IMM_W = 8;

   // opcodes, instruction bits 15 to 11
   localparam logic [OPC_W-1:0] OP_HALT  = 5'b00000;
   localparam logic [OPC_W-1:0] OP_NOP   = 5'b00001;
   localparam logic [OPC_W-1:0] OP_ADDI  = 5'b01000;
   localparam logic [OPC_W-1:0] OP_SUBI  = 5'b01001;
   localparam logic [OPC_W-1:0] OP_ST    = 5'b10000;
   localparam logic [OPC_W-1:0] OP_LD    = 5'b10001;
   localparam logic [OPC_W-1:0] OP_LBI   = 5'b11000;
   localparam logic [OPC_W-1:0] OP_ALU_R = 5'b11011;

   // r-format function codes in the low two bits
   localparam logic [FUNC_W-1:0] FN_ADD = 2'b00;
   localparam logic [FUNC_W-1:0] FN_SUB = 2'b01;
   localparam logic [FUNC_W-1:0] FN_AND = 2'b10;
   localparam logic [FUNC_W-1:0] FN_XOR = 2'b11;

   // one instruction word, seen as r-format or i-format
   // lbi takes its destination from i_fmt.rs and its immediate from the low byte
   // st keeps the data register in i_fmt.rd
   typedef union packed {
      struct packed {
         logic [OPC_W-1:0]  opcode;
         logic [REG_W-1:0]  rs;
         logic [REG_W-1:0]  rt;
         logic [REG_W-1:0]  rd;
         logic [FUNC_W-1:0] func;
      } r_fmt;
      struct packed {
         logic [OPC_W-1:0] opcode;
         logic [REG_W-1:0] rs;
         logic [REG_W-1:0] rd;
         logic [IMM_W-1:0] imm5;
      } i_fmt;
   } instr_u;

endpackage
